/* verilog/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry, two ways of four single-word sets
`define CACHE_WAYS 2
`define CACHE_SETS 4

// bus widths shared by the core side and the memory side
`define ADDR_W 32
`define DATA_W 64

// bits 2..0 select the byte inside the word, the set index sits right above
`define INDEX_LO 3
`define TAG_LO 5
`define INDEX_W (`TAG_LO - `INDEX_LO)
`define TAG_W (`ADDR_W - `TAG_LO)
`define STRB_W (`DATA_W / 8)

`endif

/* verilog/apbPkg.sv */
`include "cache_macros.svh"

package apbPkg;

    // requester side of an APB link
    // the same type serves the core port and the memory port
    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [`ADDR_W-1:0]   paddr;
        logic [`DATA_W-1:0]   pwdata;
        // one strobe per byte lane of pwdata
        logic [`STRB_W-1:0]   pstrb;
    } apbReq_t;

    // completer side of an APB link
    // prdata and pslverr only count in the cycle where pready is high
    typedef struct packed {
        logic                 pready;
        logic [`DATA_W-1:0]   prdata;
        logic                 pslverr;
    } apbRsp_t;

endpackage

/* verilog/cachePkg.sv */
`include "cache_macros.svh"

package cachePkg;

    // address fields as the ways see them
    typedef logic [`INDEX_W-1:0] index_t;
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`DATA_W-1:0] data_t;

    // answer of one way for the looked-up set
    // hit already includes the valid bit
    typedef struct packed {
        logic   hit;
        data_t  data;
    } lookup_t;

    // write command broadcast to every way
    // only the way whose enable bit is set takes it
    // a fill and a merged update look the same from the way's side
    typedef struct packed {
        logic [`CACHE_WAYS-1:0] en;
        index_t                 index;
        tag_t                   tag;
        data_t                  data;
    } wayWrite_t;

    // all ways folded into one result
    // merged is the hit word with the write strobes applied
    typedef struct packed {
        logic                   hit;
        logic [`CACHE_WAYS-1:0] way;
        data_t                  rdata;
        data_t                  merged;
    } hitResult_t;

endpackage

/* verilog/cacheWay.sv */
`timescale 1ns/100ps
`include "cache_macros.svh"

module cacheWay #(
    // bit of the one-hot write enable that belongs to this way
    parameter int wayId = 0
) (
    input  logic                clk,
    input  logic                rst,
    input  cachePkg::index_t    lookupIndex,
    input  cachePkg::tag_t      lookupTag,
    output cachePkg::lookup_t   look,
    output logic                valid,
    input  cachePkg::wayWrite_t wayWr
);

    // one word and one tag per set
    cachePkg::data_t dataMem [`CACHE_SETS];
    cachePkg::tag_t tagMem [`CACHE_SETS];

    // valid bits, one per set
    logic [`CACHE_SETS-1:0] validQ;

    logic wrEn;

    // this way is addressed when its own bit of the enable is set
    assign wrEn = wayWr.en[wayId];

    // storage arrays, written on a fill or on a merged write hit
    always_ff @(posedge clk) begin
        if (wrEn) begin
            dataMem[wayWr.index] <= wayWr.data;
            tagMem[wayWr.index] <= wayWr.tag;
        end
    end

    // any write into a set leaves that set valid
    // nothing ever clears a single entry, only reset empties the way
    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= '0;
        end else if (wrEn) begin
            validQ[wayWr.index] <= 1'b1;
        end
    end

    // valid of the looked-up set goes to the controller for the victim choice
    assign valid = validQ[lookupIndex];

    // combinational lookup so that a read hit can answer in its first access cycle
    always_comb begin
        look.hit = valid && (tagMem[lookupIndex] == lookupTag);
        look.data = dataMem[lookupIndex];
    end

endmodule

/* verilog/wayCombine.sv */
`timescale 1ns/100ps
`include "cache_macros.svh"

module wayCombine (
    input  logic [`DATA_W-1:0]    wdata,
    input  logic [`STRB_W-1:0]    wstrb,
    input  cachePkg::lookup_t     looks [`CACHE_WAYS],
    output cachePkg::hitResult_t  hit
);

    always_comb begin
        hit = '0;

        // fold the ways together
        // a tag lives in one way only, so at most one hit bit is set
        // and OR-ing the gated words yields the data of the hitting way
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit.way[w] = looks[w].hit;
            hit.hit = hit.hit | looks[w].hit;
            if (looks[w].hit) begin
                hit.rdata = hit.rdata | looks[w].data;
            end
        end

        // byte merge for a write hit
        // lanes with their strobe set take the new byte, the rest keep the cached one
        // on a miss rdata is zero and the result is never written anywhere
        for (int b = 0; b < `STRB_W; b++) begin
            if (wstrb[b]) begin
                hit.merged[8*b +: 8] = wdata[8*b +: 8];
            end else begin
                hit.merged[8*b +: 8] = hit.rdata[8*b +: 8];
            end
        end
    end

endmodule

/* verilog/accessControl.sv */
`timescale 1ns/100ps
`include "cache_macros.svh"

module accessControl (
    input  logic                    clk,
    input  logic                    rst,
    input  apbPkg::apbReq_t         up,
    output apbPkg::apbRsp_t         upRsp,
    output apbPkg::apbReq_t         dn,
    input  apbPkg::apbRsp_t         dnRsp,
    output cachePkg::index_t        lookupIndex,
    output cachePkg::tag_t          lookupTag,
    input  cachePkg::hitResult_t    hit,
    input  logic [`CACHE_WAYS-1:0]  validVec,
    output cachePkg::wayWrite_t     wayWr
);

    // idle waits for an upstream access, request is the downstream setup cycle,
    // wait holds the downstream access until pready, respond answers the core
    typedef enum logic [1:0] {
        stIdle,
        stReq,
        stWait,
        stResp
    } state_t;

    state_t state;
    state_t stateNext;

    // round-robin bit per set, picks way 1 when set and way 0 when clear
    logic [`CACHE_SETS-1:0] rrQ;

    // downstream reply kept for the upstream response cycle
    logic [`DATA_W-1:0] rdataQ;
    logic errQ;

    logic upAccess;
    logic readHit;
    logic dnDone;
    logic fill;
    logic update;
    logic [`CACHE_WAYS-1:0] victim;

    // the core holds paddr stable until pready, so the lookup runs straight off it
    assign lookupIndex = up.paddr[`TAG_LO-1:`INDEX_LO];
    assign lookupTag = up.paddr[`ADDR_W-1:`TAG_LO];

    assign upAccess = up.psel && up.penable;
    // only a fresh read in idle is answered from the ways
    assign readHit = (state == stIdle) && upAccess && !up.pwrite && hit.hit;
    assign dnDone = (state == stWait) && dnRsp.pready;
    // a failed read leaves the set untouched
    assign fill = dnDone && !up.pwrite && !dnRsp.pslverr;
    // a write that the memory rejected is not merged either
    assign update = dnDone && up.pwrite && hit.hit && !dnRsp.pslverr;

    // victim choice, the lowest invalid way wins over the round-robin pick
    always_comb begin
        victim = '0;
        victim[rrQ[lookupIndex]] = 1'b1;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!validVec[w]) begin
                victim = '0;
                victim[w] = 1'b1;
            end
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                // writes and read misses both go to memory
                if (upAccess && !readHit) begin
                    stateNext = stReq;
                end
            end
            stReq: stateNext = stWait;
            stWait: begin
                if (dnRsp.pready) begin
                    stateNext = stResp;
                end
            end
            default: stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    // the round-robin bit flips on every fill of its set, write merges leave it alone
    always_ff @(posedge clk) begin
        if (rst) begin
            rrQ <= '0;
        end else if (fill) begin
            rrQ[lookupIndex] <= ~rrQ[lookupIndex];
        end
    end

    always_ff @(posedge clk) begin
        if (dnDone) begin
            rdataQ <= dnRsp.prdata;
            errQ <= dnRsp.pslverr;
        end
    end

    // downstream request copies the upstream fields, only the handshake is our own
    always_comb begin
        dn = up;
        dn.psel = (state == stReq) || (state == stWait);
        dn.penable = (state == stWait);
    end

    always_comb begin
        upRsp.pready = readHit || (state == stResp);
        upRsp.prdata = (state == stResp) ? rdataQ : hit.rdata;
        upRsp.pslverr = (state == stResp) && errQ;
    end

    // one write port for both cases: a fill takes the memory word into the victim,
    // a write hit puts the merged word back into the way that holds it
    always_comb begin
        wayWr.index = lookupIndex;
        wayWr.tag = lookupTag;
        wayWr.en = '0;
        wayWr.data = dnRsp.prdata;
        if (fill) begin
            wayWr.en = victim;
        end
        if (update) begin
            wayWr.en = hit.way;
            wayWr.data = hit.merged;
        end
    end

endmodule

/* verilog/cacheTop.sv */
`timescale 1ns/100ps
`include "cache_macros.svh"

module cacheTop (
    input  logic            clk,
    input  logic            rst,
    input  apbPkg::apbReq_t up,
    output apbPkg::apbRsp_t upRsp,
    output apbPkg::apbReq_t dn,
    input  apbPkg::apbRsp_t dnRsp
);

    // lookup address shared by all ways
    cachePkg::index_t lookupIndex;
    cachePkg::tag_t lookupTag;

    // per-way answers and the folded result
    cachePkg::lookup_t looks [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] validVec;
    cachePkg::hitResult_t hitRes;

    // write command broadcast back into the ways
    cachePkg::wayWrite_t wayWr;

    accessControl accessControl_inst (
        .clk         (clk),
        .rst         (rst),
        .up          (up),
        .upRsp       (upRsp),
        .dn          (dn),
        .dnRsp       (dnRsp),
        .lookupIndex (lookupIndex),
        .lookupTag   (lookupTag),
        .hit         (hitRes),
        .validVec    (validVec),
        .wayWr       (wayWr)
    );

    for (genvar g = 0; g < `CACHE_WAYS; g++) begin : gWay
        cacheWay #(
            .wayId (g)
        ) cacheWay_inst (
            .clk         (clk),
            .rst         (rst),
            .lookupIndex (lookupIndex),
            .lookupTag   (lookupTag),
            .look        (looks[g]),
            .valid       (validVec[g]),
            .wayWr       (wayWr)
        );
    end

    // the merge uses the upstream write data and strobes directly
    wayCombine wayCombine_inst (
        .wdata (up.pwdata),
        .wstrb (up.pstrb),
        .looks (looks),
        .hit   (hitRes)
    );

endmodule

/* tb/cacheTop_chk.sv */
`timescale 1ns/100ps
`include "cache_macros.svh"

module cacheTop_chk (
    input logic                   clk,
    input logic                   rst,
    input apbPkg::apbReq_t        up,
    input apbPkg::apbRsp_t        upRsp,
    input apbPkg::apbReq_t        dn,
    input apbPkg::apbRsp_t        dnRsp,
    input logic [`CACHE_WAYS-1:0] hitWay
);

    // number of assertion failures since the start of the run
    int failCount = 0;

    // a downstream access cycle always comes straight out of a setup cycle
    dnSetupFirst: assert property (@(posedge clk) disable iff (rst)
        $rose(dn.penable) |-> $past(dn.psel) && !$past(dn.penable))
        else begin
            failCount++;
            $error("downstream penable rose without a setup cycle before it");
        end

    // the memory sees one fixed address from setup until it answers
    dnAddrStable: assert property (@(posedge clk) disable iff (rst)
        dn.psel && !(dn.penable && dnRsp.pready) |=> $stable(dn.paddr))
        else begin
            failCount++;
            $error("downstream paddr changed while waiting for pready");
        end

    // the core may only be answered inside its own access cycle
    upReadyInAccess: assert property (@(posedge clk) disable iff (rst)
        upRsp.pready |-> up.psel && up.penable)
        else begin
            failCount++;
            $error("upstream pready outside of an access cycle");
        end

    // a tag never lives in two ways of one set
    oneWayHits: assert property (@(posedge clk) disable iff (rst) $onehot0(hitWay))
        else begin
            failCount++;
            $error("more than one way hit the same lookup");
        end

endmodule

bind cacheTop cacheTop_chk cacheTop_chk_inst (
    .clk    (clk),
    .rst    (rst),
    .up     (up),
    .upRsp  (upRsp),
    .dn     (dn),
    .dnRsp  (dnRsp),
    .hitWay (hitRes.way)
);

/* tb/cacheTop_tb.sv */
`timescale 1ns/100ps
`include "cache_macros.svh"

module cacheTop_tb;

    localparam int directedTx = 12;
    localparam int randomTx = 300;
    localparam int cycleLimit = 200 * (directedTx + randomTx) + 100;
    // the memory rejects this one word, which sits alone in set 3
    localparam logic [`ADDR_W-1:0] errAddr = 32'h0000_ff18;

    // one upstream transaction and the downstream traffic it caused
    typedef struct packed {
        logic                write;
        logic [`ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0]  wdata;
        logic [`STRB_W-1:0]  strb;
        logic [`DATA_W-1:0]  rdata;
        logic                err;
        logic [31:0]         dnTx;
        apbPkg::apbReq_t     dnReq;
    } txRecord_t;

    logic clk;
    logic rst;
    apbPkg::apbReq_t up;
    apbPkg::apbRsp_t upRsp;
    apbPkg::apbReq_t dn;
    apbPkg::apbRsp_t dnRsp;

    // memory contents behind the cache, and the shadow copy the checks predict from
    logic [`DATA_W-1:0] memWords [logic [`ADDR_W-1:0]];
    logic [`DATA_W-1:0] refMem [logic [`ADDR_W-1:0]];
    apbPkg::apbReq_t lastDn;
    int dnCount = 0;
    int issuedCount = 0;
    int comparedCount = 0;
    txRecord_t records [$];

    // mirrored tags, valid bits and round-robin bits of the cache
    logic [`TAG_W-1:0] mTag [`CACHE_WAYS][`CACHE_SETS];
    logic mValid [`CACHE_WAYS][`CACHE_SETS];
    logic mRr [`CACHE_SETS];

    cacheTop cacheTop_inst (
        .clk   (clk),
        .rst   (rst),
        .up    (up),
        .upRsp (upRsp),
        .dn    (dn),
        .dnRsp (dnRsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // words nobody has written yet get a pattern that every address bit changes
    function automatic logic [`DATA_W-1:0] fillWord(logic [`ADDR_W-1:0] addr);
        return {addr ^ 32'h5a3c_96e1, {addr[15:0], addr[31:16]} + 32'h3d71_0c29};
    endfunction

    function automatic logic [`DATA_W-1:0] mergeBytes(logic [`DATA_W-1:0] old,
            logic [`DATA_W-1:0] wdata, logic [`STRB_W-1:0] strb);
        logic [`DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < `STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [`DATA_W-1:0] readMem(logic [`ADDR_W-1:0] addr);
        return memWords.exists(addr) ? memWords[addr] : fillWord(addr);
    endfunction

    // expected read data comes from the shadow memory alone
    function automatic logic [`DATA_W-1:0] expectedRead(logic [`ADDR_W-1:0] addr);
        return refMem.exists(addr) ? refMem[addr] : fillWord(addr);
    endfunction

    // the pool holds ten addresses with five tags on each of sets 1 and 2
    function automatic logic [`ADDR_W-1:0] poolAddr(int k);
        logic [`TAG_W-1:0] tag;
        logic [`INDEX_W-1:0] set;
        tag = `TAG_W'(32'h40 + k % 5);
        set = (k < 5) ? 2'd1 : 2'd2;
        return {tag, set, 3'b000};
    endfunction

    // returns the mirror way that holds the address or -1 on a miss
    function automatic int lookupWay(logic [`ADDR_W-1:0] addr);
        int set;
        set = addr[`TAG_LO-1:`INDEX_LO];
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (mValid[w][set] && mTag[w][set] == addr[`ADDR_W-1:`TAG_LO]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // first invalid way wins, otherwise the round-robin bit names the victim
    function automatic void allocateLine(logic [`ADDR_W-1:0] addr);
        int set;
        int victim;
        set = addr[`TAG_LO-1:`INDEX_LO];
        victim = mRr[set];
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!mValid[w][set]) begin
                victim = w;
            end
        end
        mValid[victim][set] = 1'b1;
        mTag[victim][set] = addr[`ADDR_W-1:`TAG_LO];
        mRr[set] = !mRr[set];
    endfunction

    task automatic checkValue(string name, logic [`DATA_W-1:0] got, logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // one APB transfer on the core side whose record goes to the compare process
    task automatic upAccess(logic write, logic [`ADDR_W-1:0] addr,
            logic [`DATA_W-1:0] wdata, logic [`STRB_W-1:0] strb);
        apbPkg::apbReq_t req;
        txRecord_t rec;
        int startCount;
        req = '0;
        req.psel = 1'b1;
        req.pwrite = write;
        req.paddr = addr;
        req.pwdata = wdata;
        req.pstrb = strb;
        startCount = dnCount;
        @(posedge clk);
        up <= req;
        req.penable = 1'b1;
        @(posedge clk);
        up <= req;
        @(negedge clk);
        while (!upRsp.pready) begin
            @(negedge clk);
        end
        rec = {write, addr, wdata, strb, upRsp.prdata, upRsp.pslverr,
            32'(dnCount - startCount), lastDn};
        @(posedge clk);
        up <= '0;
        records.push_back(rec);
        issuedCount++;
    endtask

    // the memory completer answers after 0 to 3 wait states
    initial begin : memoryModel
        apbPkg::apbRsp_t rsp;
        int waits;
        dnRsp = '0;
        forever begin
            @(negedge clk);
            if (dn.psel && !dn.penable) begin
                dnCount++;
                lastDn = dn;
                rsp = '0;
                rsp.pready = 1'b1;
                if (dn.pwrite) begin
                    memWords[dn.paddr] = mergeBytes(readMem(dn.paddr), dn.pwdata, dn.pstrb);
                end else begin
                    rsp.prdata = readMem(dn.paddr);
                    rsp.pslverr = (dn.paddr == errAddr);
                end
                waits = $urandom_range(3, 0);
                @(posedge clk);
                repeat (waits) @(posedge clk);
                dnRsp <= rsp;
                @(posedge clk);
                dnRsp <= '0;
            end
        end
    end

    // the compare process runs the reference model in transaction order
    initial begin : compare
        txRecord_t rec;
        int way;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            mRr[s] = 1'b0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                mValid[w][s] = 1'b0;
            end
        end
        forever begin
            wait (records.size() > 0);
            rec = records.pop_front();
            way = lookupWay(rec.addr);
            if (rec.write) begin
                // write-through keeps address, data and strobes untouched
                checkValue("dnCount", rec.dnTx, 1);
                checkValue("dn.pwrite", rec.dnReq.pwrite, 1'b1);
                checkValue("dn.paddr", rec.dnReq.paddr, rec.addr);
                checkValue("dn.pwdata", rec.dnReq.pwdata, rec.wdata);
                checkValue("dn.pstrb", rec.dnReq.pstrb, rec.strb);
                checkValue("upRsp.pslverr", rec.err, 1'b0);
                refMem[rec.addr] = mergeBytes(expectedRead(rec.addr), rec.wdata, rec.strb);
            end else begin
                checkValue("upRsp.pslverr", rec.err, rec.addr == errAddr);
                checkValue("dnCount", rec.dnTx, (way < 0) ? 1 : 0);
                if (way < 0) begin
                    checkValue("dn.pwrite", rec.dnReq.pwrite, 1'b0);
                    checkValue("dn.paddr", rec.dnReq.paddr, rec.addr);
                end
                if (!rec.err) begin
                    checkValue("upRsp.prdata", rec.rdata, expectedRead(rec.addr));
                end
                // a failed read leaves the set as it was
                if (way < 0 && rec.addr != errAddr) begin
                    allocateLine(rec.addr);
                end
            end
            comparedCount++;
        end
    end

    // a failed bound assertion ends the run as a failed compare does
    initial begin : assertionWatch
        wait (cacheTop_inst.cacheTop_chk_inst.failCount != 0);
        $display("an assertion in the bound protocol checker failed");
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first assertion failure");
    end

    initial begin : timeoutWatch
        int cycleCount;
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped by the cycle limit");
    end

    initial begin : stimulus
        logic [`DATA_W-1:0] data;
        int k;
        void'($urandom(32'hd9c91170));
        rst = 1'b1;
        up = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // a cold miss followed by a hit on the same word
        upAccess(1'b0, poolAddr(0), '0, '0);
        upAccess(1'b0, poolAddr(0), '0, '0);
        // three tags fight over the two ways of set 1
        upAccess(1'b0, poolAddr(1), '0, '0);
        upAccess(1'b0, poolAddr(2), '0, '0);
        upAccess(1'b0, poolAddr(0), '0, '0);
        upAccess(1'b0, poolAddr(1), '0, '0);
        // a partial write on a cached word whose read back must hit the merged line
        upAccess(1'b1, poolAddr(1), 64'h1122_3344_5566_7788, 8'b0011_0101);
        upAccess(1'b0, poolAddr(1), '0, '0);
        // write miss without allocation
        upAccess(1'b1, poolAddr(3), 64'hcafe_0123_4567_89ab, 8'hf0);
        upAccess(1'b0, poolAddr(3), '0, '0);
        // the error address is read twice and the retry still misses
        upAccess(1'b0, errAddr, '0, '0);
        upAccess(1'b0, errAddr, '0, '0);
        repeat (randomTx) begin
            k = $urandom_range(9, 0);
            data = {$urandom, $urandom};
            upAccess($urandom_range(2, 0) == 0, poolAddr(k), data,
                8'($urandom_range(255, 1)));
        end
        wait (comparedCount == issuedCount);
        // assertions sampled on the last rising edge have settled by the falling edge
        @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* cacheTop.f */
+incdir+verilog
verilog/apbPkg.sv
verilog/cachePkg.sv
verilog/cacheWay.sv
verilog/wayCombine.sv
verilog/accessControl.sv
verilog/cacheTop.sv
tb/cacheTop_chk.sv
tb/cacheTop_tb.sv

/* Bender.yml */
package:
  name: cacheTop

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/apbPkg.sv
      - verilog/cachePkg.sv
      - verilog/cacheWay.sv
      - verilog/wayCombine.sv
      - verilog/accessControl.sv
      - verilog/cacheTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/cacheTop_chk.sv
      - tb/cacheTop_tb.sv
